// ==== sim/loader_stim.txt ====
# H host_byte_addr data | W word_addr lanes(bit1 UDS, bit0 LDS) data | R word_addr expected
# B wait until load idle | S expected_busy expected_overflow
S 0 0
H FF000000 01
H FF000000 00
H FF000000 02
H 00000100 12
H 00000101 34
H 00010020 56
H 00010021 78
H 00018040 9A
H 00018041 BC
B
H FF000000 00
R 000080 1234
R 008010 5678
R 00C020 9ABC
W 000080 3 FFFF
R 000080 1234
W 00C020 1 00EE
R 00C020 9AEE
# Loads while the CPU owns memory
H 00018060 11
H 00018061 22
H 00018062 33
H 00018063 44
S 1 0
H 00018064 55
H 00018065 66
H 00018066 77
H 00018067 88
H 00018068 99
H 00018069 AA
S 1 0
H 00000100 DE
H 00000101 AD
S 1 1
H FF000000 02
B
H FF000000 00
R 00C030 1122
R 00C031 3344
R 00C034 99AA
R 000080 1234
S 0 1

// ==== m68k_loader.f ====
+incdir+verilog
verilog/bus_pkg.sv
verilog/loader_pkg.sv
verilog/loader_word_assembler.sv
verilog/load_word_fifo.sv
verilog/bus_memory.sv
verilog/m68k_loader_top.sv
sim/tb_m68k_loader.sv

// ==== sim/tb_m68k_loader.sv ====
`timescale 1ns/1ps
`include "m68k_loader_defines.svh"

module tb_m68k_loader;

  logic        clk_cpu = 1'b0;
  logic        i_reset;
  logic        i_host_wr;
  logic [31:0] i_host_addr;
  logic [7:0]  i_host_data;
  logic        i_cpu_as_n;
  logic        i_cpu_rw;
  logic        i_cpu_uds_n;
  logic        i_cpu_lds_n;
  logic [22:0] i_cpu_addr;
  logic [15:0] i_cpu_dout;
  logic [15:0] o_cpu_din;
  logic        o_cpu_reset;
  logic        o_load_busy;
  logic        o_load_overflow;

  // Stimulus, one entry per operation line
  byte         op_q [$];
  logic [31:0] fa_q [$];
  logic [31:0] fb_q [$];
  logic [31:0] fc_q [$];

  // ==============================
  // Reference model
  // ==============================
  logic [15:0] model_mem [2**`MEM_ADDR_BITS];
  logic [7:0]  model_ctrl;
  logic [7:0]  model_even;          // Upper byte of the next word
  int          model_pending;       // Words parked while the CPU owns memory
  logic        model_ovf;

  int errors      = 0;
  int checks      = 0;
  int cycles      = 0;
  int cycle_limit = 200;

  m68k_loader_top u_dut (
    .clk_cpu         (clk_cpu),
    .i_reset         (i_reset),
    .i_host_wr       (i_host_wr),
    .i_host_addr     (i_host_addr),
    .i_host_data     (i_host_data),
    .i_cpu_as_n      (i_cpu_as_n),
    .i_cpu_rw        (i_cpu_rw),
    .i_cpu_uds_n     (i_cpu_uds_n),
    .i_cpu_lds_n     (i_cpu_lds_n),
    .i_cpu_addr      (i_cpu_addr),
    .i_cpu_dout      (i_cpu_dout),
    .o_cpu_din       (o_cpu_din),
    .o_cpu_reset     (o_cpu_reset),
    .o_load_busy     (o_load_busy),
    .o_load_overflow (o_load_overflow)
  );

  always #50 clk_cpu = ~clk_cpu;    // 100 ns period

  // Run length guard
  always @(posedge clk_cpu)
  begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, stimulus did not complete", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic read_stimulus(output bit ok);
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("sim/loader_stim.txt", "r");
    ok = (fd != 0);
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#" && line[0] != "\n")  // Skip comments, blanks
        begin
          a = '0;
          b = '0;
          c = '0;
          n = $sscanf(line, "%c %h %h %h", op, a, b, c);
          op_q.push_back(op);
          fa_q.push_back(a);
          fb_q.push_back(b);
          fc_q.push_back(c);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic bus_idle();
    i_cpu_as_n  = 1'b1;
    i_cpu_rw    = 1'b1;
    i_cpu_uds_n = 1'b1;
    i_cpu_lds_n = 1'b1;
  endtask

  // Word completion as the load path treats it
  task automatic model_load_word(input logic [22:0] waddr, input logic [15:0] word);
    if (model_ctrl[`CTRL_LOADER_OWNS_BIT])
      model_mem[waddr[`MEM_ADDR_BITS-1:0]] = word;
    else if (model_pending == `LOAD_FIFO_DEPTH + 1)
      model_ovf = 1'b1;             // FIFO full and one word held, new word lost
    else
    begin
      model_pending++;
      model_mem[waddr[`MEM_ADDR_BITS-1:0]] = word;
    end
  endtask

  // ==============================
  // Bus operations
  // ==============================
  task automatic host_write(input logic [31:0] addr, input logic [7:0] data);
    @(negedge clk_cpu);
    i_host_wr   = 1'b1;             // Single-cycle strobe
    i_host_addr = addr;
    i_host_data = data;
    @(negedge clk_cpu);
    i_host_wr = 1'b0;
    if (addr[31:24] == `CONTROL_PAGE)
    begin
      model_ctrl = data;
      if (data[`CTRL_LOADER_OWNS_BIT])
        model_pending = 0;          // Parked words drain into memory
      checks++;
      if (o_cpu_reset !== model_ctrl[`CTRL_CPU_RESET_BIT])
      begin
        $display("ERROR o_cpu_reset: expected 0x%h, got 0x%h",
                 model_ctrl[`CTRL_CPU_RESET_BIT], o_cpu_reset);
        errors++;
      end
    end
    else if (addr[31:24] == `LOAD_PAGE && !addr[0])
      model_even = data;
    else if (addr[31:24] == `LOAD_PAGE)
      model_load_word(addr[23:1], {model_even, data});  // Big-endian
  endtask

  task automatic cpu_write(input logic [22:0] addr, input logic [1:0] lanes,
                           input logic [15:0] data);
    logic [`MEM_ADDR_BITS-1:0] idx;
    idx = addr[`MEM_ADDR_BITS-1:0];
    @(negedge clk_cpu);
    i_cpu_as_n  = 1'b0;
    i_cpu_rw    = 1'b0;
    i_cpu_uds_n = !lanes[1];
    i_cpu_lds_n = !lanes[0];
    i_cpu_addr  = addr;
    i_cpu_dout  = data;
    @(negedge clk_cpu);
    bus_idle();
    // ROM ignores writes, RAM regions take lanes
    if (!model_ctrl[`CTRL_LOADER_OWNS_BIT] && addr[`MEM_ADDR_BITS-1 -: 3] >= `REGION_VRAM)
    begin
      if (lanes[1])
        model_mem[idx][15:8] = data[15:8];
      if (lanes[0])
        model_mem[idx][7:0] = data[7:0];
    end
  endtask

  task automatic cpu_read_check(input logic [22:0] addr, input logic [15:0] expected);
    checks++;
    if (model_mem[addr[`MEM_ADDR_BITS-1:0]] !== expected)
    begin
      $display("ERROR stim o_cpu_din at 0x%h: file 0x%h, model 0x%h",
               addr, expected, model_mem[addr[`MEM_ADDR_BITS-1:0]]);
      errors++;
    end
    @(negedge clk_cpu);
    i_cpu_as_n  = 1'b0;
    i_cpu_rw    = 1'b1;
    i_cpu_uds_n = 1'b0;
    i_cpu_lds_n = 1'b0;
    i_cpu_addr  = addr;
    @(negedge clk_cpu);             // Data one cycle after the strobe
    bus_idle();
    checks++;
    if (o_cpu_din !== expected)
    begin
      $display("ERROR o_cpu_din at 0x%h: expected 0x%h, got 0x%h", addr, expected, o_cpu_din);
      errors++;
    end
  endtask

  task automatic wait_load_idle();
    int waited;
    waited = 0;
    while (o_load_busy && waited < 50)
    begin
      @(negedge clk_cpu);
      waited++;
    end
    checks++;
    if (o_load_busy)
    begin
      $display("Load path still busy after 50 cycles");
      errors++;
    end
  endtask

  task automatic check_status(input logic busy, input logic ovf);
    checks++;
    if (busy !== (model_pending != 0) || ovf !== model_ovf)
    begin
      $display("ERROR stim status: file 0x%h, model 0x%h",
               {busy, ovf}, {model_pending != 0, model_ovf});
      errors++;
    end
    checks++;
    if (o_load_busy !== busy)
    begin
      $display("ERROR o_load_busy: expected 0x%h, got 0x%h", busy, o_load_busy);
      errors++;
    end
    checks++;
    if (o_load_overflow !== ovf)
    begin
      $display("ERROR o_load_overflow: expected 0x%h, got 0x%h", ovf, o_load_overflow);
      errors++;
    end
  endtask

  task automatic run_op(input int i);
    case (op_q[i])
      "H": host_write(fa_q[i], fb_q[i][7:0]);
      "W": cpu_write(fa_q[i][22:0], fb_q[i][1:0], fc_q[i][15:0]);
      "R": cpu_read_check(fa_q[i][22:0], fb_q[i][15:0]);
      "B": wait_load_idle();
      "S": check_status(fa_q[i][0], fb_q[i][0]);
      default:
      begin
        $display("Unknown operation on stimulus entry %0d", i);
        errors++;
      end
    endcase
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial
  begin
    bit ok;
    int i;
    i_reset       = 1'b1;
    i_host_wr     = 1'b0;
    i_host_addr   = '0;
    i_host_data   = '0;
    i_cpu_addr    = '0;
    i_cpu_dout    = '0;
    bus_idle();
    model_ctrl    = '0;
    model_even    = '0;
    model_pending = 0;
    model_ovf     = 1'b0;
    read_stimulus(ok);
    cycle_limit = 200 + 20 * op_q.size();
    repeat (3) @(posedge clk_cpu);
    @(negedge clk_cpu);
    checks++;
    if (o_cpu_reset !== 1'b1)
    begin
      $display("ERROR o_cpu_reset: expected 0x1, got 0x%h", o_cpu_reset);
      errors++;
    end
    i_reset = 1'b0;
    @(negedge clk_cpu);
    checks++;
    if (o_cpu_reset !== 1'b0 || o_load_busy !== 1'b0 || o_load_overflow !== 1'b0)
    begin
      $display("ERROR reset status {o_cpu_reset,o_load_busy,o_load_overflow}: "
               , "expected 0x0, got 0x%h", {o_cpu_reset, o_load_busy, o_load_overflow});
      errors++;
    end
    if (!ok)
    begin
      $display("Could not open stimulus file sim/loader_stim.txt");
      errors++;
    end
    for (i = 0; i < op_q.size(); i++)
      run_op(i);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== verilog/m68k_loader_top.sv ====
`timescale 1ns/1ps
`include "m68k_loader_defines.svh"

module m68k_loader_top
  import bus_pkg::*, loader_pkg::*;
#(
  parameter int FIFO_DEPTH = `LOAD_FIFO_DEPTH
)
(
  input  logic       clk_cpu,
  input  logic       i_reset,
  // Host loader port
  input  logic       i_host_wr,
  input  host_addr_t i_host_addr,
  input  host_byte_t i_host_data,
  // 68000 bus
  input  logic       i_cpu_as_n,
  input  logic       i_cpu_rw,
  input  logic       i_cpu_uds_n,
  input  logic       i_cpu_lds_n,
  input  cpu_addr_t  i_cpu_addr,
  input  bus_word_t  i_cpu_dout,
  output bus_word_t  o_cpu_din,
  // Status
  output logic       o_cpu_reset,
  output logic       o_load_busy,     // Word held or buffered
  output logic       o_load_overflow
);

  ctrl_reg_t ctrl;
  logic      loader_owns;
  logic      load_valid;              // Assembler to FIFO
  logic      load_ready;
  cpu_addr_t load_addr;
  bus_word_t load_data;
  logic      fifo_valid;              // FIFO to memory
  logic      fifo_ready;
  cpu_addr_t fifo_addr;
  bus_word_t fifo_data;
  logic      fifo_empty;

  assign loader_owns = ctrl[`CTRL_LOADER_OWNS_BIT];
  assign o_cpu_reset = i_reset || ctrl[`CTRL_CPU_RESET_BIT];
  assign o_load_busy = load_valid || !fifo_empty;

  // ==============================
  // Host bytes to words
  // ==============================
  loader_word_assembler u_assembler (
    .clk_cpu      (clk_cpu),
    .i_reset      (i_reset),
    .i_host_wr    (i_host_wr),
    .i_host_addr  (i_host_addr),
    .i_host_data  (i_host_data),
    .i_load_ready (load_ready),
    .o_load_valid (load_valid),
    .o_load_addr  (load_addr),
    .o_load_data  (load_data),
    .o_ctrl       (ctrl),
    .o_overflow   (o_load_overflow)
  );

  load_word_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_cpu      (clk_cpu),
    .i_reset      (i_reset),
    .i_push_valid (load_valid),
    .i_push_addr  (load_addr),
    .i_push_data  (load_data),
    .o_push_ready (load_ready),
    .o_pop_valid  (fifo_valid),
    .o_pop_addr   (fifo_addr),
    .o_pop_data   (fifo_data),
    .i_pop_ready  (fifo_ready),
    .o_empty      (fifo_empty)
  );

  // ==============================
  // Shared memory
  // ==============================
  bus_memory u_memory (
    .clk_cpu       (clk_cpu),
    .i_loader_owns (loader_owns),
    .i_load_valid  (fifo_valid),
    .i_load_addr   (fifo_addr),
    .i_load_data   (fifo_data),
    .o_load_ready  (fifo_ready),
    .i_cpu_as_n    (i_cpu_as_n),
    .i_cpu_rw      (i_cpu_rw),
    .i_cpu_uds_n   (i_cpu_uds_n),
    .i_cpu_lds_n   (i_cpu_lds_n),
    .i_cpu_addr    (i_cpu_addr),
    .i_cpu_dout    (i_cpu_dout),
    .o_cpu_din     (o_cpu_din)
  );

endmodule

// ==== verilog/bus_memory.sv ====
`timescale 1ns/1ps
`include "m68k_loader_defines.svh"

module bus_memory
  import bus_pkg::*;
(
  input  logic      clk_cpu,
  input  logic      i_loader_owns,    // Control bit 1
  // Load words from the FIFO
  input  logic      i_load_valid,
  input  cpu_addr_t i_load_addr,
  input  bus_word_t i_load_data,
  output logic      o_load_ready,
  // 68000 bus
  input  logic      i_cpu_as_n,
  input  logic      i_cpu_rw,         // 1 read, 0 write
  input  logic      i_cpu_uds_n,
  input  logic      i_cpu_lds_n,
  input  cpu_addr_t i_cpu_addr,
  input  bus_word_t i_cpu_dout,
  output bus_word_t o_cpu_din
);

  localparam int MEM_WORDS = 2 ** `MEM_ADDR_BITS;

  bus_word_t                 mem [MEM_WORDS];  // ROM, VRAM and work RAM together
  region_t                   cpu_region;
  logic                      cpu_cycle;        // Strobed access while CPU owns
  logic                      cpu_wr_ok;        // Write into a RAM region
  logic [`MEM_ADDR_BITS-1:0] cpu_idx;
  logic [`MEM_ADDR_BITS-1:0] wr_idx;
  bus_word_t                 wr_data;
  logic                      wr_hi;            // Upper lane enable
  logic                      wr_lo;            // Lower lane enable

  // ==============================
  // Region decode
  // ==============================
  assign cpu_idx    = i_cpu_addr[`MEM_ADDR_BITS-1:0];     // CPU bits 17:1
  assign cpu_region = i_cpu_addr[`MEM_ADDR_BITS-1 -: 3];  // CPU bits 17:15
  assign cpu_cycle  = !i_loader_owns && !i_cpu_as_n;
  assign cpu_wr_ok  = cpu_cycle && !i_cpu_rw && (cpu_region >= `REGION_VRAM);

  // Loader always accepted while it owns memory
  assign o_load_ready = i_loader_owns;

  // Single write port, owner picks the source
  always_comb
  begin
    if (i_loader_owns)
    begin
      wr_idx  = i_load_addr[`MEM_ADDR_BITS-1:0];
      wr_data = i_load_data;
      wr_hi   = i_load_valid;          // Full words, any region
      wr_lo   = i_load_valid;
    end
    else
    begin
      wr_idx  = cpu_idx;
      wr_data = i_cpu_dout;
      wr_hi   = cpu_wr_ok && !i_cpu_uds_n;
      wr_lo   = cpu_wr_ok && !i_cpu_lds_n;
    end
  end

  // Byte-lane write, same edge as the handshake
  always_ff @(posedge clk_cpu)
  begin
    if (wr_hi)
      mem[wr_idx][15:8] <= wr_data[15:8];
    if (wr_lo)
      mem[wr_idx][7:0] <= wr_data[7:0];
  end

  // ==============================
  // CPU read
  // ==============================
  // Registered, one cycle after the strobe
  // Holds its last value while the loader owns memory
  always_ff @(posedge clk_cpu)
  begin
    if (cpu_cycle && i_cpu_rw)
      o_cpu_din <= mem[cpu_idx];
  end

  // Accepted load words only under loader ownership, written whole
  a_no_load_cpu_owns: assert property (
    @(posedge clk_cpu)
    i_load_valid && o_load_ready |->
      i_loader_owns && wr_hi && wr_lo && (wr_data == i_load_data)
  );

endmodule

// ==== verilog/load_word_fifo.sv ====
`timescale 1ns/1ps
`include "m68k_loader_defines.svh"

module load_word_fifo
  import bus_pkg::*;
#(
  parameter int DEPTH = `LOAD_FIFO_DEPTH
)
(
  input  logic      clk_cpu,
  input  logic      i_reset,
  // Push side, from the assembler
  input  logic      i_push_valid,
  input  cpu_addr_t i_push_addr,
  input  bus_word_t i_push_data,
  output logic      o_push_ready,     // Low when full
  // Pop side, towards memory
  output logic      o_pop_valid,      // Low when empty
  output cpu_addr_t o_pop_addr,
  output bus_word_t o_pop_data,
  input  logic      i_pop_ready,
  output logic      o_empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  cpu_addr_t        addr_mem [DEPTH];
  bus_word_t        data_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;           // Words held, 0..DEPTH
  logic             push;
  logic             pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign o_push_ready = (count != CNT_W'(DEPTH));
  assign o_pop_valid  = (count != '0);
  assign o_empty      = (count == '0);
  assign o_pop_addr   = addr_mem[rd_ptr];   // Head entry, shown one cycle after push
  assign o_pop_data   = data_mem[rd_ptr];

  assign push = i_push_valid && o_push_ready;
  assign pop  = o_pop_valid && i_pop_ready;

  // Entry storage
  always_ff @(posedge clk_cpu)
  begin
    if (push)
    begin
      addr_mem[wr_ptr] <= i_push_addr;
      data_mem[wr_ptr] <= i_push_data;
    end
  end

  // ==============================
  // Pointers and count
  // ==============================
  always_ff @(posedge clk_cpu)
  begin
    if (i_reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_next(wr_ptr);
      if (pop)
        rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                       // Both or neither, count holds
      endcase
    end
  end

  a_count_bound: assert property (
    @(posedge clk_cpu) disable iff (i_reset)
    count <= CNT_W'(DEPTH)
  );

endmodule

// ==== verilog/loader_word_assembler.sv ====
`timescale 1ns/1ps
`include "m68k_loader_defines.svh"

module loader_word_assembler
  import loader_pkg::*, bus_pkg::*;
(
  input  logic       clk_cpu,
  input  logic       i_reset,
  // Host byte port
  input  logic       i_host_wr,     // One-cycle pulse, no handshake
  input  host_addr_t i_host_addr,
  input  host_byte_t i_host_data,
  // Completed word towards the FIFO
  input  logic       i_load_ready,
  output logic       o_load_valid,
  output cpu_addr_t  o_load_addr,
  output bus_word_t  o_load_data,
  // Control and status
  output ctrl_reg_t  o_ctrl,
  output logic       o_overflow     // Sticky, a word was lost
);

  logic [7:0] host_page;            // Top address byte
  logic       ctrl_wr;
  logic       load_wr;
  logic       word_done;            // Odd byte closes the word
  logic       word_taken;           // Handshake on this edge
  logic       word_stuck;           // Held word cannot leave
  host_byte_t even_byte_q;          // Upper half waiting for its partner

  // ==============================
  // Page decode
  // ==============================
  assign host_page  = i_host_addr[31:24];
  assign ctrl_wr    = i_host_wr && (host_page == `CONTROL_PAGE);
  assign load_wr    = i_host_wr && (host_page == `LOAD_PAGE);
  assign word_done  = load_wr && i_host_addr[0];
  assign word_taken = o_load_valid && i_load_ready;
  assign word_stuck = o_load_valid && !i_load_ready;

  // Control register, valid and overflow
  always_ff @(posedge clk_cpu)
  begin
    if (i_reset)
    begin
      o_ctrl       <= '0;
      o_load_valid <= 1'b0;
      o_overflow   <= 1'b0;
    end
    else
    begin
      if (ctrl_wr)
        o_ctrl <= i_host_data;          // Whole byte replaced
      if (word_done && word_stuck)
        o_overflow <= 1'b1;             // New word dropped, old one kept
      else if (word_done)
        o_load_valid <= 1'b1;           // Also covers take and refill together
      else if (word_taken)
        o_load_valid <= 1'b0;
    end
  end

  // ==============================
  // Byte slots and held word
  // ==============================
  always_ff @(posedge clk_cpu)
  begin
    if (load_wr && !i_host_addr[0])
      even_byte_q <= i_host_data;       // Even address is the upper byte
    if (word_done && !word_stuck)
    begin
      o_load_addr <= i_host_addr[23:1];
      o_load_data <= {even_byte_q, i_host_data};  // Big-endian word
    end
  end

  // Held word keeps valid and payload until the FIFO takes it
  a_hold_stable: assert property (
    @(posedge clk_cpu) disable iff (i_reset)
    word_stuck |=> o_load_valid && $stable(o_load_data) && $stable(o_load_addr)
  );

endmodule

// ==== verilog/loader_pkg.sv ====
package loader_pkg;

  // ==============================
  // Host loader side
  // ==============================

  // Host byte address, top byte selects the page
  typedef logic [31:0] host_addr_t;

  // One byte as written by the host
  typedef logic [7:0] host_byte_t;

  // Control register image
  // Bit 0 CPU reset, bit 1 loader owns memory
  typedef logic [7:0] ctrl_reg_t;

endpackage

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

  // ==============================
  // 68000 side of the design
  // ==============================

  // One data word, upper byte on the UDS lane
  typedef logic [15:0] bus_word_t;

  // Word address, CPU bits 23:1
  // Bit 0 of this type is A1
  typedef logic [22:0] cpu_addr_t;

  // Memory region code, CPU bits 17:15
  // 0..1 ROM, 2 video RAM, 3..7 work RAM
  typedef logic [2:0] region_t;

endpackage

// ==== verilog/m68k_loader_defines.svh ====
`ifndef M68K_LOADER_DEFINES_SVH
`define M68K_LOADER_DEFINES_SVH

// ==============================
// Host address pages
// ==============================
// Page is the top byte of the 32-bit host byte address
`define CONTROL_PAGE 8'hFF  // Control register, any offset
`define LOAD_PAGE    8'h00  // Memory load window, bytes 23:0

// ==============================
// CPU memory map
// ==============================
// Region is CPU address bits 17:15
// Codes below VRAM are ROM, codes above are work RAM
`define REGION_VRAM 3'd2

// Word address bits that index memory, CPU bits 17:1
`define MEM_ADDR_BITS 17

// ==============================
// Control register bits
// ==============================
`define CTRL_CPU_RESET_BIT   0  // Hold the 68000 in reset
`define CTRL_LOADER_OWNS_BIT 1  // Memory belongs to the loader

// Words buffered between assembler and memory
`define LOAD_FIFO_DEPTH 4

`endif
